/* design/ctrl_pkg.sv */
//////////////////////////////////////////////////////////////////////
// core controller shared types
// pc source codes toward fetch, jump kinds from the decoder and
// operand forwarding selects
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // pc mux
  //////////////////////////////////////////////////////////////////////

  // pc source requested from the fetch stage
  // codes are fixed by the fetch stage mux
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  //////////////////////////////////////////////////////////////////////
  // control transfer kind
  //////////////////////////////////////////////////////////////////////

  // jal and jalr resolve in decode, cond branches resolve in EX
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_e;

  //////////////////////////////////////////////////////////////////////
  // operand forwarding
  //////////////////////////////////////////////////////////////////////

  // source of an ID-stage operand
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

endpackage

`default_nettype wire

/* design/ctrl_fsm.sv */
//////////////////////////////////////////////////////////////////////
// core controller state machine
// sequences boot, sleep, first fetch, decode and WFI flush, and
// raises the pc redirect for jumps, branches, exceptions and eret
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // run control and exception request
  input  logic    fetch_enable_i,
  input  logic    exc_req_i,

  // decode side
  input  logic    instr_valid_i,
  input  logic    branch_taken_ex_i,
  input  jump_e   jump_in_dec_i,
  input  logic    eret_insn_i,
  input  logic    pipe_flush_i,

  // pipeline progress
  input  logic    id_ready_i,
  input  logic    ex_valid_i,

  // jalr operand hazard from the stall logic
  input  logic    jr_stall_i,

  output logic    instr_req_o,
  output logic    ctrl_busy_o,
  output logic    is_decoding_o,

  // fetch redirect
  output logic    pc_set_o,
  output pc_mux_e pc_mux_o,

  // exception controller strobes
  output logic    exc_ack_o,
  output logic    exc_save_if_o,
  output logic    exc_save_id_o,
  output logic    exc_restore_id_o,

  output logic    halt_if_o,
  output logic    halt_id_o
);

  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // a jump or eret redirect already went out for the instruction in ID
  logic jump_done_q;
  logic jump_done_d;

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d          = state_q;
    jump_done_d      = jump_done_q;

    // running core fetches and is busy unless a state says otherwise
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    is_decoding_o    = 1'b0;

    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;

    exc_ack_o        = 1'b0;
    exc_save_if_o    = 1'b0;
    exc_save_id_o    = 1'b0;
    exc_restore_id_o = 1'b0;

    halt_if_o        = 1'b0;
    halt_id_o        = 1'b0;

    case (state_q)
      // idle out of reset, nothing fetched yet
      RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load the boot address into the fetch pc
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // pipeline is empty, wake on enable or a pending exception
      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait here while the first instruction misses in IF
      FIRST_FETCH:
      begin
        if (id_ready_i)
          state_d = DECODE;

        // nothing valid in ID yet, so the IF pc is the one to save
        if (exc_req_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE:
      begin
        // a taken branch in EX kills the instruction in ID
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if ((jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR))
          begin
            // target is known in decode, redirect once
            // jalr waits for its base register to settle
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            // trap on the ID instruction, keep it out of EX
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            exc_save_id_o = 1'b1;
            halt_id_o     = 1'b1;
          end

          // eret takes the mux over whatever was picked above
          if (eret_insn_i)
          begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // WFI, or eret back into a core that is not enabled
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // branch resolved taken in EX wins over everything in ID
        if (branch_taken_ex_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_BRANCH;
          is_decoding_o = 1'b0;
        end
      end

      // drain EX, hold the front of the pipe
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // drain WB, then resume or go to sleep
      FLUSH_WB:
      begin
        halt_id_o = 1'b1;
        halt_if_o = !fetch_enable_i;
        if (fetch_enable_i)
          state_d = DECODE;
        else
          state_d = SLEEP;
      end

      // unused encoding, fall back to reset
      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // ID accepting means the next instruction arrives, rearm the jump
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
//////////////////////////////////////////////////////////////////////
// pipeline hazard detection
// load-use and jalr operand stalls, misaligned stall and write
// enable deassertion for the instruction in ID
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hazard_unit
  import ctrl_pkg::*;
(
  input  logic  is_decoding_i,
  input  logic  illegal_insn_i,

  // LSU state in EX
  input  logic  data_req_ex_i,
  input  logic  data_misaligned_i,

  input  jump_e jump_in_dec_i,

  // pending register writes
  input  logic  regfile_we_ex_i,
  input  logic  regfile_we_wb_i,
  input  logic  regfile_alu_we_fw_i,

  // destination matches against the ID sources
  input  logic  reg_d_ex_is_reg_a_i,
  input  logic  reg_d_ex_is_reg_b_i,
  input  logic  reg_d_ex_is_reg_c_i,
  input  logic  reg_d_wb_is_reg_a_i,
  input  logic  reg_d_alu_is_reg_a_i,

  output logic  load_stall_o,
  output logic  jr_stall_o,
  output logic  misaligned_stall_o,
  output logic  deassert_we_o
);

  logic ex_src_match;
  logic jr_base_pending;

  // EX destination hits any operand of the ID instruction
  assign ex_src_match = reg_d_ex_is_reg_a_i | reg_d_ex_is_reg_b_i | reg_d_ex_is_reg_c_i;

  // load data only shows up in WB, so a dependent op has to wait
  assign load_stall_o = data_req_ex_i & regfile_we_ex_i & ex_src_match;

  // jalr base register still in flight on any write path
  assign jr_base_pending = (regfile_we_ex_i     & reg_d_ex_is_reg_a_i)  |
                           (regfile_alu_we_fw_i & reg_d_alu_is_reg_a_i) |
                           (regfile_we_wb_i     & reg_d_wb_is_reg_a_i);

  // jump target feeds the pc directly, no forwarding there
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & jr_base_pending;

  // second half of a misaligned access holds ID
  assign misaligned_stall_o = data_misaligned_i;

  // no register write for an instruction that is not being decoded,
  // is illegal, or is held back by a stall
  assign deassert_we_o = ~is_decoding_i |
                         illegal_insn_i |
                         load_stall_o   |
                         jr_stall_o;

endmodule

`default_nettype wire

/* design/operand_fwd_unit.sv */
//////////////////////////////////////////////////////////////////////
// operand forwarding select
// picks register file, EX or WB data for ID operands a, b and c
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module operand_fwd_unit
  import ctrl_pkg::*;
(
  input  logic    regfile_we_wb_i,
  input  logic    regfile_alu_we_fw_i,
  input  logic    data_misaligned_i,
  input  logic    mult_multicycle_i,

  // WB destination matches
  input  logic    reg_d_wb_is_reg_a_i,
  input  logic    reg_d_wb_is_reg_b_i,
  input  logic    reg_d_wb_is_reg_c_i,

  // ALU/MUL destination matches
  input  logic    reg_d_alu_is_reg_a_i,
  input  logic    reg_d_alu_is_reg_b_i,
  input  logic    reg_d_alu_is_reg_c_i,

  output fw_sel_e operand_a_fw_sel_o,
  output fw_sel_e operand_b_fw_sel_o,
  output fw_sel_e operand_c_fw_sel_o
);

  always_comb
  begin
    operand_a_fw_sel_o = SEL_REGFILE;
    operand_b_fw_sel_o = SEL_REGFILE;
    operand_c_fw_sel_o = SEL_REGFILE;

    // older result from WB
    if (regfile_we_wb_i)
    begin
      if (reg_d_wb_is_reg_a_i)
        operand_a_fw_sel_o = SEL_FW_WB;
      if (reg_d_wb_is_reg_b_i)
        operand_b_fw_sel_o = SEL_FW_WB;
      if (reg_d_wb_is_reg_c_i)
        operand_c_fw_sel_o = SEL_FW_WB;
    end

    // younger result from EX is the newer value, so it wins
    if (regfile_alu_we_fw_i)
    begin
      if (reg_d_alu_is_reg_a_i)
        operand_a_fw_sel_o = SEL_FW_EX;
      if (reg_d_alu_is_reg_b_i)
        operand_b_fw_sel_o = SEL_FW_EX;
      if (reg_d_alu_is_reg_c_i)
        operand_c_fw_sel_o = SEL_FW_EX;
    end

    // misaligned access reuses the EX address for its second half
    // multicycle mul keeps its partial result on operand c
    if (data_misaligned_i)
    begin
      operand_a_fw_sel_o = SEL_FW_EX;
      operand_b_fw_sel_o = SEL_REGFILE;
    end
    else if (mult_multicycle_i)
      operand_c_fw_sel_o = SEL_FW_EX;
  end

endmodule

`default_nettype wire

/* design/core_controller.sv */
//////////////////////////////////////////////////////////////////////
// core pipeline controller
// state machine, hazard detection and operand forwarding select
// for a small in-order RV32 core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_controller
  import ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  input  logic    fetch_enable_i,
  input  logic    exc_req_i,

  // from decode and the IF/ID register
  input  logic    instr_valid_i,
  input  logic    branch_taken_ex_i,
  input  jump_e   jump_in_dec_i,
  input  jump_e   jump_in_id_i,
  input  logic    eret_insn_i,
  input  logic    pipe_flush_i,
  input  logic    illegal_insn_i,

  // stage handshakes
  input  logic    id_ready_i,
  input  logic    ex_valid_i,

  // LSU and multiplier
  input  logic    data_req_ex_i,
  input  logic    data_misaligned_i,
  input  logic    mult_multicycle_i,

  // register write enables per path
  input  logic    regfile_we_ex_i,
  input  logic    regfile_we_wb_i,
  input  logic    regfile_alu_we_fw_i,

  // destination vs source matches
  input  logic    reg_d_ex_is_reg_a_i,
  input  logic    reg_d_ex_is_reg_b_i,
  input  logic    reg_d_ex_is_reg_c_i,
  input  logic    reg_d_wb_is_reg_a_i,
  input  logic    reg_d_wb_is_reg_b_i,
  input  logic    reg_d_wb_is_reg_c_i,
  input  logic    reg_d_alu_is_reg_a_i,
  input  logic    reg_d_alu_is_reg_b_i,
  input  logic    reg_d_alu_is_reg_c_i,

  output logic    instr_req_o,
  output logic    ctrl_busy_o,
  output logic    pc_set_o,
  output pc_mux_e pc_mux_o,
  output logic    exc_ack_o,
  output logic    exc_save_if_o,
  output logic    exc_save_id_o,
  output logic    exc_restore_id_o,
  output logic    halt_if_o,
  output logic    halt_id_o,

  output logic    load_stall_o,
  output logic    jr_stall_o,
  output logic    misaligned_stall_o,
  output logic    deassert_we_o,

  output fw_sel_e operand_a_fw_sel_o,
  output fw_sel_e operand_b_fw_sel_o,
  output fw_sel_e operand_c_fw_sel_o
);

  // state machine is in decode with a live instruction in ID
  logic is_decoding;

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  // jalr hazard loops back from the stall logic to hold the jump
  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .exc_req_i         (exc_req_i),
    .instr_valid_i     (instr_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .jr_stall_i        (jr_stall_o),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ack_o         (exc_ack_o),
    .exc_save_if_o     (exc_save_if_o),
    .exc_save_id_o     (exc_save_id_o),
    .exc_restore_id_o  (exc_restore_id_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  //////////////////////////////////////////////////////////////////////
  // stalls and forwarding
  //////////////////////////////////////////////////////////////////////

  hazard_unit u_hazard_unit (
    .is_decoding_i        (is_decoding),
    .illegal_insn_i       (illegal_insn_i),
    .data_req_ex_i        (data_req_ex_i),
    .data_misaligned_i    (data_misaligned_i),
    .jump_in_dec_i        (jump_in_dec_i),
    .regfile_we_ex_i      (regfile_we_ex_i),
    .regfile_we_wb_i      (regfile_we_wb_i),
    .regfile_alu_we_fw_i  (regfile_alu_we_fw_i),
    .reg_d_ex_is_reg_a_i  (reg_d_ex_is_reg_a_i),
    .reg_d_ex_is_reg_b_i  (reg_d_ex_is_reg_b_i),
    .reg_d_ex_is_reg_c_i  (reg_d_ex_is_reg_c_i),
    .reg_d_wb_is_reg_a_i  (reg_d_wb_is_reg_a_i),
    .reg_d_alu_is_reg_a_i (reg_d_alu_is_reg_a_i),
    .load_stall_o         (load_stall_o),
    .jr_stall_o           (jr_stall_o),
    .misaligned_stall_o   (misaligned_stall_o),
    .deassert_we_o        (deassert_we_o)
  );

  operand_fwd_unit u_operand_fwd_unit (
    .regfile_we_wb_i      (regfile_we_wb_i),
    .regfile_alu_we_fw_i  (regfile_alu_we_fw_i),
    .data_misaligned_i    (data_misaligned_i),
    .mult_multicycle_i    (mult_multicycle_i),
    .reg_d_wb_is_reg_a_i  (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i  (reg_d_wb_is_reg_b_i),
    .reg_d_wb_is_reg_c_i  (reg_d_wb_is_reg_c_i),
    .reg_d_alu_is_reg_a_i (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i (reg_d_alu_is_reg_b_i),
    .reg_d_alu_is_reg_c_i (reg_d_alu_is_reg_c_i),
    .operand_a_fw_sel_o   (operand_a_fw_sel_o),
    .operand_b_fw_sel_o   (operand_b_fw_sel_o),
    .operand_c_fw_sel_o   (operand_c_fw_sel_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_core_controller.sv */
//////////////////////////////////////////////////////////////////////
// core controller testbench
// random stimulus against a cycle model of the controller FSM,
// the hazard checks and the operand forwarding priority
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_core_controller
  import ctrl_pkg::*;
();

  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 5;
  localparam int RUN_CYCLES    = 5000;
  localparam int MARGIN_CYCLES = 100;
  localparam int TIMEOUT_NS    = (RUN_CYCLES + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  // model copy of the controller states
  typedef enum logic [2:0] {
    M_RESET,
    M_BOOT_SET,
    M_SLEEP,
    M_FIRST_FETCH,
    M_DECODE,
    M_FLUSH_EX,
    M_FLUSH_WB
  } model_state_e;

  logic    clk;
  logic    rst_n;

  // DUT inputs
  logic    fetch_enable_i, exc_req_i, instr_valid_i, branch_taken_ex_i;
  jump_e   jump_in_dec_i, jump_in_id_i;
  logic    eret_insn_i, pipe_flush_i, illegal_insn_i;
  logic    id_ready_i, ex_valid_i;
  logic    data_req_ex_i, data_misaligned_i, mult_multicycle_i;
  logic    regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic    reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i;
  logic    reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i;
  logic    reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i;

  // DUT outputs
  logic    instr_req_o, ctrl_busy_o, pc_set_o;
  pc_mux_e pc_mux_o;
  logic    exc_ack_o, exc_save_if_o, exc_save_id_o, exc_restore_id_o;
  logic    halt_if_o, halt_id_o;
  logic    load_stall_o, jr_stall_o, misaligned_stall_o, deassert_we_o;
  fw_sel_e operand_a_fw_sel_o, operand_b_fw_sel_o, operand_c_fw_sel_o;

  // reference model state
  model_state_e m_state;
  model_state_e m_state_nxt;
  logic         m_jump_done;
  logic         m_jump_set;

  // expected outputs for the current cycle
  logic    e_instr_req, e_busy, e_decoding, e_pc_set;
  pc_mux_e e_pc_mux;
  logic    e_exc_ack, e_save_if, e_save_id, e_restore, e_halt_if, e_halt_id;
  logic    e_load_stall, e_jr_stall, e_mis_stall, e_deassert;
  fw_sel_e e_fw_a, e_fw_b, e_fw_c;

  int cycle;
  int check_count;
  int error_count;
  int visits [7];

  core_controller u_core_controller (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // true with the given chance in percent
  function automatic logic chance(input int percent);
    return ($urandom_range(99) < percent);
  endfunction

  task automatic drive_random_inputs();
    fetch_enable_i       = chance(90);
    exc_req_i            = chance(5);
    instr_valid_i        = chance(80);
    branch_taken_ex_i    = chance(15);
    eret_insn_i          = chance(5);
    pipe_flush_i         = chance(5);
    illegal_insn_i       = chance(10);
    id_ready_i           = chance(70);
    ex_valid_i           = chance(70);
    data_req_ex_i        = chance(30);
    data_misaligned_i    = chance(15);
    mult_multicycle_i    = chance(15);
    regfile_we_ex_i      = chance(50);
    regfile_we_wb_i      = chance(50);
    regfile_alu_we_fw_i  = chance(50);
    reg_d_ex_is_reg_a_i  = chance(30);
    reg_d_ex_is_reg_b_i  = chance(30);
    reg_d_ex_is_reg_c_i  = chance(30);
    reg_d_wb_is_reg_a_i  = chance(30);
    reg_d_wb_is_reg_b_i  = chance(30);
    reg_d_wb_is_reg_c_i  = chance(30);
    reg_d_alu_is_reg_a_i = chance(30);
    reg_d_alu_is_reg_b_i = chance(30);
    reg_d_alu_is_reg_c_i = chance(30);
    case ($urandom_range(3))
      0: jump_in_dec_i = BRANCH_NONE;
      1: jump_in_dec_i = BRANCH_JAL;
      2: jump_in_dec_i = BRANCH_JALR;
      default: jump_in_dec_i = BRANCH_COND;
    endcase
    // id-stage copy is not used by the controller
    jump_in_id_i = jump_in_dec_i;
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // forced EX beats forced regfile, which beats ALU and then WB
  function automatic fw_sel_e expected_fw_sel(input logic force_ex, input logic force_rf,
                                              input logic alu_hit, input logic wb_hit);
    if (force_ex)
      return SEL_FW_EX;
    if (force_rf)
      return SEL_REGFILE;
    if (alu_hit)
      return SEL_FW_EX;
    if (wb_hit)
      return SEL_FW_WB;
    return SEL_REGFILE;
  endfunction

  task automatic predict_hazards();
    e_load_stall = data_req_ex_i && regfile_we_ex_i &&
                   (reg_d_ex_is_reg_a_i || reg_d_ex_is_reg_b_i || reg_d_ex_is_reg_c_i);
    // jalr base register written by any path still in flight
    e_jr_stall   = (jump_in_dec_i == BRANCH_JALR) &&
                   ((regfile_we_ex_i && reg_d_ex_is_reg_a_i) ||
                    (regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i) ||
                    (regfile_we_wb_i && reg_d_wb_is_reg_a_i));
    e_mis_stall  = data_misaligned_i;
    e_fw_a = expected_fw_sel(data_misaligned_i, 1'b0,
                             regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i,
                             regfile_we_wb_i && reg_d_wb_is_reg_a_i);
    e_fw_b = expected_fw_sel(1'b0, data_misaligned_i,
                             regfile_alu_we_fw_i && reg_d_alu_is_reg_b_i,
                             regfile_we_wb_i && reg_d_wb_is_reg_b_i);
    e_fw_c = expected_fw_sel(!data_misaligned_i && mult_multicycle_i, 1'b0,
                             regfile_alu_we_fw_i && reg_d_alu_is_reg_c_i,
                             regfile_we_wb_i && reg_d_wb_is_reg_c_i);
  endtask

  task automatic predict_decode();
    if (branch_taken_ex_i)
    begin
      // taken branch kills ID whatever it holds
      e_pc_set = 1'b1;
      e_pc_mux = PC_BRANCH;
    end
    else if (instr_valid_i)
    begin
      e_decoding = 1'b1;
      if ((jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR))
      begin
        e_pc_mux = PC_JUMP;
        if (!e_jr_stall && !m_jump_done)
        begin
          e_pc_set   = 1'b1;
          m_jump_set = 1'b1;
        end
      end
      else if (exc_req_i)
      begin
        e_pc_set  = 1'b1;
        e_pc_mux  = PC_EXCEPTION;
        e_exc_ack = 1'b1;
        e_save_id = 1'b1;
        e_halt_id = 1'b1;
      end
      if (eret_insn_i)
      begin
        e_pc_mux  = PC_ERET;
        e_restore = 1'b1;
        if (!m_jump_done)
        begin
          e_pc_set   = 1'b1;
          m_jump_set = 1'b1;
        end
      end
      if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
      begin
        e_halt_if   = 1'b1;
        e_halt_id   = 1'b1;
        m_state_nxt = M_FLUSH_EX;
      end
    end
  endtask

  task automatic predict_fsm();
    m_state_nxt = m_state;
    m_jump_set  = 1'b0;
    e_instr_req = 1'b1;
    e_busy      = 1'b1;
    e_decoding  = 1'b0;
    e_pc_set    = 1'b0;
    e_pc_mux    = PC_BOOT;
    e_exc_ack   = 1'b0;
    e_save_if   = 1'b0;
    e_save_id   = 1'b0;
    e_restore   = 1'b0;
    e_halt_if   = 1'b0;
    e_halt_id   = 1'b0;
    case (m_state)
      M_RESET:
      begin
        e_instr_req = 1'b0;
        e_busy      = 1'b0;
        if (fetch_enable_i)
          m_state_nxt = M_BOOT_SET;
      end
      M_BOOT_SET:
      begin
        e_pc_set    = 1'b1;
        m_state_nxt = M_FIRST_FETCH;
      end
      M_SLEEP:
      begin
        e_instr_req = 1'b0;
        e_busy      = 1'b0;
        e_halt_if   = 1'b1;
        e_halt_id   = 1'b1;
        if (fetch_enable_i || exc_req_i)
          m_state_nxt = M_FIRST_FETCH;
      end
      M_FIRST_FETCH:
      begin
        if (exc_req_i)
        begin
          e_pc_set  = 1'b1;
          e_pc_mux  = PC_EXCEPTION;
          e_exc_ack = 1'b1;
          e_save_if = 1'b1;
        end
        if (id_ready_i)
          m_state_nxt = M_DECODE;
      end
      M_DECODE:
        predict_decode();
      M_FLUSH_EX:
      begin
        e_halt_if = 1'b1;
        e_halt_id = 1'b1;
        if (ex_valid_i)
          m_state_nxt = M_FLUSH_WB;
      end
      M_FLUSH_WB:
      begin
        e_halt_id   = 1'b1;
        e_halt_if   = !fetch_enable_i;
        m_state_nxt = fetch_enable_i ? M_DECODE : M_SLEEP;
      end
      default:
        m_state_nxt = M_RESET;
    endcase
    // write enable drops for anything not decoded or held back
    e_deassert = !e_decoding || illegal_insn_i || e_load_stall || e_jr_stall;
  endtask

  // register update at the coming rising edge
  task automatic advance_model();
    m_state     = m_state_nxt;
    m_jump_done = (m_jump_done || m_jump_set) && !id_ready_i;
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("FAIL %s cycle %0d expected %0b actual %0b", name, cycle, expected, actual);
    end
  endtask

  task automatic check_code(input string name, input logic [2:0] expected,
                            input logic [2:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("FAIL %s cycle %0d expected %0h actual %0h", name, cycle, expected, actual);
    end
  endtask

  task automatic compare_outputs();
    check_bit("instr_req", e_instr_req, instr_req_o);
    check_bit("ctrl_busy", e_busy, ctrl_busy_o);
    check_bit("pc_set", e_pc_set, pc_set_o);
    check_code("pc_mux", e_pc_mux, pc_mux_o);
    check_bit("exc_ack", e_exc_ack, exc_ack_o);
    check_bit("exc_save_if", e_save_if, exc_save_if_o);
    check_bit("exc_save_id", e_save_id, exc_save_id_o);
    check_bit("exc_restore_id", e_restore, exc_restore_id_o);
    check_bit("halt_if", e_halt_if, halt_if_o);
    check_bit("halt_id", e_halt_id, halt_id_o);
    check_bit("load_stall", e_load_stall, load_stall_o);
    check_bit("jr_stall", e_jr_stall, jr_stall_o);
    check_bit("misaligned_stall", e_mis_stall, misaligned_stall_o);
    check_bit("deassert_we", e_deassert, deassert_we_o);
    check_code("operand_a_fw_sel", {1'b0, e_fw_a}, {1'b0, operand_a_fw_sel_o});
    check_code("operand_b_fw_sel", {1'b0, e_fw_b}, {1'b0, operand_b_fw_sel_o});
    check_code("operand_c_fw_sel", {1'b0, e_fw_c}, {1'b0, operand_c_fw_sel_o});
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int seed_ret;
    seed_ret    = $urandom(32'h4499);
    check_count = 0;
    error_count = 0;
    cycle       = 0;
    foreach (visits[i])
      visits[i] = 0;
    m_state     = M_RESET;
    m_jump_done = 1'b0;

    // quiet pipeline while in reset
    rst_n = 1'b0;
    drive_random_inputs();
    fetch_enable_i = 1'b0;
    exc_req_i      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (cycle = 0; cycle < RUN_CYCLES; cycle++)
    begin
      drive_random_inputs();
      // clean boot with enable on and no exception up to the first fetch
      if (cycle < 3)
      begin
        fetch_enable_i = 1'b1;
        exc_req_i      = 1'b0;
      end
      @(negedge clk);
      visits[m_state]++;
      predict_hazards();
      predict_fsm();
      compare_outputs();
      advance_model();
      @(posedge clk);
      #1;
    end

    // the bias should carry the FSM through every state
    foreach (visits[i])
    begin
      if (visits[i] == 0)
      begin
        error_count++;
        $display("controller state %0d was never visited during the run", i);
      end
    end

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns before the run completed", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/ctrl_pkg.sv
design/ctrl_fsm.sv
design/hazard_unit.sv
design/operand_fwd_unit.sv
design/core_controller.sv
testbench/tb_core_controller.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_core_controller
FLIST     := flist.f
PASS_MSG  := Regression passed

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FLIST))

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fxq "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
